/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = axi_mem_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bench/axi_mem_tb.sv */
/*
 * Directed testbench for the AXI4 memory slave.
 * Drives the channels on the falling clock edge, models the memory as a
 * byte array and checks responses, IDs, last flags and read data.
 */
module axi_mem_tb;
  import axi_mem_pkg::*;

  localparam int SEED        = 99431;
  localparam int TOTAL_BEATS = 29;
  // Channel numbers for wait_high
  localparam int AW = 0, W = 1, B = 2, AR = 3, R = 4;

  logic       clk_i, arst_n_i;
  logic       aw_valid_i, w_valid_i, w_last_i, b_ready_i, ar_valid_i, r_ready_i;
  logic       aw_ready_o, w_ready_o, b_valid_o, ar_ready_o, r_valid_o, r_last_o;
  id_t        aw_id_i, ar_id_i, b_id_o, r_id_o;
  addr_t      aw_addr_i, ar_addr_i;
  len_t       aw_len_i, ar_len_i;
  burst_t     aw_burst_i, ar_burst_i;
  data_t      w_data_i, r_data_o;
  strb_t      w_strb_i;
  resp_t      b_resp_o, r_resp_o;
  logic [7:0] ref_mem [1 << ADDR_W];
  int         errors = 0;
  int         failed = 0;
  logic       ar_hold = 1'b0;

  axi_mem_top dut0 (.*);

  always #5 clk_i = ~clk_i;

  task automatic note_error(string name, logic [31:0] exp, logic [31:0] act);
    $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    errors++;
  endtask

  task automatic cmp_data(string name, data_t exp, data_t act);
    if (act !== exp) note_error(name, 32'(exp), 32'(act));
  endtask

  task automatic cmp_resp(string name, resp_t exp, resp_t act);
    if (act !== exp) note_error(name, 32'(exp), 32'(act));
  endtask

  task automatic cmp_id(string name, id_t exp, id_t act);
    if (act !== exp) note_error(name, 32'(exp), 32'(act));
  endtask

  task automatic cmp_bit(string name, logic exp, logic act);
    if (act !== exp) note_error(name, 32'(exp), 32'(act));
  endtask

  // Byte index of lane b in beat n of a FIXED or INCR burst
  function automatic int byte_idx(addr_t start, burst_t burst, int n, int b);
    addr_t a;
    a = (burst == BURST_FIXED) ? start : start + addr_t'(4 * n);
    return int'({a[ADDR_W-1:2], 2'(b)});
  endfunction

  // From a falling edge, waits until the DUT side of a channel is high
  task automatic wait_high(int ch);
    logic [4:0] dut_side;
    #1;
    dut_side = {r_valid_o, ar_ready_o, b_valid_o, w_ready_o, aw_ready_o};
    while (!dut_side[ch]) begin
      @(negedge clk_i);
      #1;
      dut_side = {r_valid_o, ar_ready_o, b_valid_o, w_ready_o, aw_ready_o};
    end
  endtask

  task automatic make_beats(int n, logic full, output data_t d[$], output strb_t s[$]);
    d.delete();
    s.delete();
    for (int i = 0; i < n; i++) begin
      d.push_back($urandom);
      s.push_back(full ? 4'hF : strb_t'($urandom));
    end
  endtask

  task automatic write_burst(id_t id, addr_t start, len_t len, burst_t burst,
                             data_t data[$], strb_t strb[$]);
    logic okay;
    okay = (burst == BURST_FIXED) || (burst == BURST_INCR);
    {aw_id_i, aw_addr_i, aw_len_i, aw_burst_i} = {id, start, len, burst};
    aw_valid_i = 1'b1;
    wait_high(AW);
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    for (int n = 0; n <= int'(len); n++) begin
      {w_data_i, w_strb_i, w_last_i} = {data[n], strb[n], n == int'(len)};
      w_valid_i = 1'b1;
      wait_high(W);
      @(negedge clk_i);
      // Bytes of a bad burst never reach the reference
      for (int b = 0; b < STRB_W; b++) begin
        if (okay && strb[n][b]) ref_mem[byte_idx(start, burst, n, b)] = data[n][8*b +: 8];
      end
    end
    {w_valid_i, w_last_i, b_ready_i} = 3'b001;
    #1;
    cmp_bit("b_valid", 1'b1, b_valid_o);
    wait_high(B);
    cmp_id("b_id", id, b_id_o);
    cmp_resp("b_resp", okay ? RESP_OKAY : RESP_SLVERR, b_resp_o);
    @(negedge clk_i);
    b_ready_i = 1'b0;
  endtask

  task automatic read_burst(id_t id, addr_t start, len_t len, burst_t burst, logic stall,
                            output data_t beats[$]);
    resp_t want_resp;
    data_t d;
    logic  last;
    want_resp = (burst == BURST_FIXED || burst == BURST_INCR) ? RESP_OKAY : RESP_SLVERR;
    beats.delete();
    {ar_id_i, ar_addr_i, ar_len_i, ar_burst_i} = {id, start, len, burst};
    ar_valid_i = 1'b1;
    wait_high(AR);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    r_ready_i  = !stall;
    for (int n = 0; n <= int'(len); n++) begin
      wait_high(R);
      d    = r_data_o;
      last = r_last_o;
      cmp_id("r_id", id, r_id_o);
      cmp_resp("r_resp", want_resp, r_resp_o);
      cmp_bit("r_last", n == int'(len), last);
      // Hold r_ready low for a few cycles
      if (stall) begin
        repeat ($urandom_range(3, 1)) begin
          @(negedge clk_i);
          #1;
          cmp_bit("r_valid", 1'b1, r_valid_o);
          cmp_data("r_data", d, r_data_o);
          cmp_id("r_id", id, r_id_o);
          cmp_bit("r_last", last, r_last_o);
        end
        @(negedge clk_i);
        r_ready_i = 1'b1;
      end
      beats.push_back(d);
      @(negedge clk_i);
      r_ready_i = !stall && (n != int'(len));
      // Fetch cycle between beats
      if (n != int'(len)) begin
        #1;
        cmp_bit("r_valid", 1'b0, r_valid_o);
      end
    end
  endtask

  task automatic check_read(addr_t start, burst_t burst, data_t beats[$]);
    data_t want;
    foreach (beats[n]) begin
      for (int b = 0; b < STRB_W; b++) want[8*b +: 8] = ref_mem[byte_idx(start, burst, n, b)];
      cmp_data("r_data", want, beats[n]);
    end
  endtask

  task automatic idle_check();
    #1;
    cmp_bit("aw_ready", 1'b1, aw_ready_o);
    cmp_bit("w_ready", 1'b0, w_ready_o);
    cmp_bit("b_valid", 1'b0, b_valid_o);
    cmp_bit("r_valid", 1'b0, r_valid_o);
    cmp_bit("r_last", 1'b0, r_last_o);
    @(negedge clk_i);
  endtask

  task automatic report(string name, int errs_before);
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: %0d errors", name, errors - errs_before);
    end
  endtask

  // ar_ready stays low while a write holds the slave
  always @(negedge clk_i) begin
    #1;
    if (ar_hold) cmp_bit("ar_ready", 1'b0, ar_ready_o);
  end

  initial begin
    repeat (40 * TOTAL_BEATS + 200) @(posedge clk_i);
    $display("Watchdog expired, a handshake never completed");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    data_t d[$];
    strb_t s[$];
    data_t beats[$];
    id_t   wid;
    int    e;
    void'($urandom(SEED));
    {clk_i, arst_n_i, aw_valid_i, w_valid_i, w_last_i, b_ready_i, ar_valid_i, r_ready_i} = '0;
    {aw_id_i, aw_addr_i, aw_len_i, aw_burst_i, w_data_i, w_strb_i} = '0;
    {ar_id_i, ar_addr_i, ar_len_i, ar_burst_i} = '0;
    repeat (3) @(negedge clk_i);
    arst_n_i = 1'b1;

    e = errors;
    idle_check();
    report("Test 1 reset state", e);

    e = errors;
    make_beats(1, 1'b1, d, s);
    write_burst(id_t'($urandom), 12'h010, 8'd0, BURST_INCR, d, s);
    read_burst(id_t'($urandom), 12'h010, 8'd0, BURST_INCR, 1'b0, beats);
    check_read(12'h010, BURST_INCR, beats);
    idle_check();
    report("Test 2 single beat", e);

    e = errors;
    make_beats(4, 1'b1, d, s);
    write_burst(id_t'($urandom), 12'h100, 8'd3, BURST_INCR, d, s);
    make_beats(4, 1'b0, d, s);
    write_burst(id_t'($urandom), 12'h100, 8'd3, BURST_INCR, d, s);
    read_burst(id_t'($urandom), 12'h100, 8'd3, BURST_INCR, 1'b0, beats);
    check_read(12'h100, BURST_INCR, beats);
    report("Test 3 INCR partial strobes", e);

    e = errors;
    make_beats(3, 1'b0, d, s);
    s[0] = 4'hF;
    write_burst(id_t'($urandom), 12'h200, 8'd2, BURST_FIXED, d, s);
    read_burst(id_t'($urandom), 12'h200, 8'd1, BURST_FIXED, 1'b0, beats);
    check_read(12'h200, BURST_FIXED, beats);
    report("Test 4 FIXED bursts", e);

    e = errors;
    make_beats(2, 1'b1, d, s);
    write_burst(id_t'($urandom), 12'h100, 8'd1, BURST_WRAP, d, s);
    read_burst(id_t'($urandom), 12'h100, 8'd1, BURST_WRAP, 1'b0, beats);
    read_burst(id_t'($urandom), 12'h100, 8'd1, BURST_INCR, 1'b0, beats);
    check_read(12'h100, BURST_INCR, beats);
    report("Test 5 WRAP rejected", e);

    e = errors;
    wid = id_t'($urandom);
    make_beats(2, 1'b1, d, s);
    // AR arrives in the same cycle as AW and waits
    {ar_id_i, ar_addr_i, ar_len_i, ar_burst_i} = {wid + 4'd1, 12'h300, 8'd1, BURST_INCR};
    ar_valid_i = 1'b1;
    ar_hold    = 1'b1;
    write_burst(wid, 12'h300, 8'd1, BURST_INCR, d, s);
    ar_hold = 1'b0;
    read_burst(wid + 4'd1, 12'h300, 8'd1, BURST_INCR, 1'b1, beats);
    check_read(12'h300, BURST_INCR, beats);
    report("Test 6 arbitration and stalls", e);

    $display("Tests run 6, failed %0d, errors %0d", failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
src/axi_mem_pkg.sv
src/axi_mem_fsm.sv
src/axi_burst_counter.sv
src/axi_mem_array.sv
src/axi_mem_top.sv
bench/axi_mem_tb.sv

/* src/axi_burst_counter.sv */
/*
 * Beat address generator for FIXED and INCR bursts.
 * Loads from AW or AR, steps once per accepted beat and flags the last
 * beat and any unsupported burst type.
 */
module axi_burst_counter (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  axi_mem_pkg::addr_t  aw_addr_i,
  input  axi_mem_pkg::len_t   aw_len_i,
  input  axi_mem_pkg::burst_t aw_burst_i,
  input  axi_mem_pkg::addr_t  ar_addr_i,
  input  axi_mem_pkg::len_t   ar_len_i,
  input  axi_mem_pkg::burst_t ar_burst_i,
  input  logic                load_wr_i,
  input  logic                load_rd_i,
  input  logic                step_i,
  output axi_mem_pkg::addr_t  addr_o,
  output logic                last_beat_o,
  output logic                burst_err_o
);
  import axi_mem_pkg::*;

  addr_t  addr_q;
  len_t   count_q;
  burst_t burst_q;
  logic   err_q;

  function automatic logic burst_bad(burst_t burst);
    unique case (burst)
      BURST_FIXED, BURST_INCR: return 1'b0;
      default:                 return 1'b1;
    endcase
  endfunction

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      addr_q  <= '0;
      count_q <= '0;
      burst_q <= BURST_INCR;
      err_q   <= 1'b0;
    end else if (load_wr_i) begin
      addr_q  <= aw_addr_i;
      count_q <= aw_len_i;
      burst_q <= aw_burst_i;
      err_q   <= burst_bad(aw_burst_i);
    end else if (load_rd_i) begin
      addr_q  <= ar_addr_i;
      count_q <= ar_len_i;
      burst_q <= ar_burst_i;
      err_q   <= burst_bad(ar_burst_i);
    end else if (step_i) begin
      count_q <= count_q - 1'b1;
      // Word step that wraps inside 4 KiB
      if (burst_q == BURST_INCR) addr_q <= addr_q + addr_t'(STRB_W);
    end
  end

  assign addr_o      = addr_q;
  assign last_beat_o = (count_q == '0);
  assign burst_err_o = err_q;

  assert property (@(posedge clk_i) disable iff (!arst_n_i) !(load_wr_i && load_rd_i));

endmodule

/* src/axi_mem_array.sv */
/*
 * Single-port word memory of the AXI4 slave.
 * Byte-masked writes and a registered read, no reset on the contents.
 */
module axi_mem_array (
  input  logic               clk_i,
  input  axi_mem_pkg::addr_t addr_i,
  input  logic               we_i,
  input  axi_mem_pkg::strb_t strb_i,
  input  axi_mem_pkg::data_t wdata_i,
  input  logic               re_i,
  output axi_mem_pkg::data_t rdata_o
);
  import axi_mem_pkg::*;

  data_t mem_q [WORDS];
  logic [ADDR_W-3:0] word_idx;

  // Byte address to word index
  assign word_idx = addr_i[ADDR_W-1:2];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (strb_i[b]) begin
          mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read register holds between fetches
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_q[word_idx];
    end
  end

  // Controller never writes and fetches in one cycle
  assert property (@(posedge clk_i) !(we_i && re_i));

endmodule

/* src/axi_mem_fsm.sv */
/*
 * Channel controller of the AXI4 memory slave.
 * Owns every ready/valid output, holds the transaction ID and tells the
 * burst counter and the memory array when to load, step, write and read.
 */
module axi_mem_fsm (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Write address
  input  logic               aw_valid_i,
  input  axi_mem_pkg::id_t   aw_id_i,
  output logic               aw_ready_o,
  // Write data
  input  logic               w_valid_i,
  input  logic               w_last_i,
  output logic               w_ready_o,
  // Write response
  input  logic               b_ready_i,
  output logic               b_valid_o,
  output axi_mem_pkg::id_t   b_id_o,
  output axi_mem_pkg::resp_t b_resp_o,
  // Read address
  input  logic               ar_valid_i,
  input  axi_mem_pkg::id_t   ar_id_i,
  output logic               ar_ready_o,
  // Read data
  input  logic               r_ready_i,
  output logic               r_valid_o,
  output axi_mem_pkg::id_t   r_id_o,
  output axi_mem_pkg::resp_t r_resp_o,
  output logic               r_last_o,
  // Burst counter
  input  logic               last_beat_i,
  input  logic               burst_err_i,
  output logic               load_wr_o,
  output logic               load_rd_o,
  output logic               step_o,
  // Memory array
  output logic               mem_we_o,
  output logic               mem_re_o
);
  import axi_mem_pkg::*;

  fsm_state_e state_q;
  fsm_state_e state_d;
  id_t        id_q;
  resp_t      resp;
  logic       aw_xfer;
  logic       ar_xfer;
  logic       w_xfer;
  logic       b_xfer;
  logic       r_xfer;

  // Write wins when AW and AR arrive together
  assign aw_ready_o = (state_q == IDLE);
  assign ar_ready_o = (state_q == IDLE) && !aw_valid_i;
  assign w_ready_o  = (state_q == WDATA);
  assign b_valid_o  = (state_q == WRESP);
  assign r_valid_o  = (state_q == RDATA);

  assign aw_xfer = aw_valid_i && aw_ready_o;
  assign ar_xfer = ar_valid_i && ar_ready_o;
  assign w_xfer  = w_valid_i && w_ready_o;
  assign b_xfer  = b_valid_o && b_ready_i;
  assign r_xfer  = r_valid_o && r_ready_i;

  assign load_wr_o = aw_xfer;
  assign load_rd_o = ar_xfer;
  assign step_o    = (w_xfer || r_xfer) && !last_beat_i;

  // Beats of a bad burst are taken but never stored
  assign mem_we_o = w_xfer && !burst_err_i;
  assign mem_re_o = (state_q == RFETCH);

  assign resp     = burst_err_i ? RESP_SLVERR : RESP_OKAY;
  assign b_id_o   = id_q;
  assign b_resp_o = resp;
  assign r_id_o   = id_q;
  assign r_resp_o = resp;
  assign r_last_o = r_valid_o && last_beat_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (aw_xfer) begin
          state_d = WDATA;
        end else if (ar_xfer) begin
          state_d = RFETCH;
        end
      end
      WDATA:  if (w_xfer && last_beat_i) state_d = WRESP;
      WRESP:  if (b_xfer) state_d = IDLE;
      RFETCH: state_d = RDATA;
      RDATA:  if (r_xfer) state_d = last_beat_i ? IDLE : RFETCH;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ID is echoed on B or on every R beat
  always_ff @(posedge clk_i) begin
    if (aw_xfer) begin
      id_q <= aw_id_i;
    end else if (ar_xfer) begin
      id_q <= ar_id_i;
    end
  end

  // Master's WLAST must agree with the beat count from AWLEN
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    w_xfer |-> (w_last_i == last_beat_i));

  // Stalled read beat keeps its fields
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (r_valid_o && !r_ready_i) |=>
      (r_valid_o && $stable(r_id_o) && $stable(r_resp_o) && $stable(r_last_o)));

endmodule

/* src/axi_mem_pkg.sv */
/*
 * Shared widths, vector types, AXI burst and response codes and the
 * controller state encoding for the AXI4 memory slave.
 * Modules import it inside their body and use scoped names in their ports.
 */
package axi_mem_pkg;

  // Bus geometry
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;
  localparam int LEN_W  = 8;

  // 4 KiB of 32-bit words
  localparam int WORDS = 1024;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [1:0]        burst_t;
  typedef logic [1:0]        resp_t;

  // AxBURST encodings, code 3 is reserved
  localparam burst_t BURST_FIXED = 2'd0;
  localparam burst_t BURST_INCR  = 2'd1;
  localparam burst_t BURST_WRAP  = 2'd2;

  // xRESP encodings in use
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // One transaction in flight at a time
  typedef enum logic [2:0] {
    IDLE,
    WDATA,
    WRESP,
    RFETCH,
    RDATA
  } fsm_state_e;

endpackage

/* src/axi_mem_top.sv */
/*
 * AXI4 memory slave, 4 KiB of 32-bit words behind the five AXI channels.
 * Serves one FIXED or INCR burst of up to 256 beats at a time.
 */
module axi_mem_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Write address
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  axi_mem_pkg::id_t    aw_id_i,
  input  axi_mem_pkg::addr_t  aw_addr_i,
  input  axi_mem_pkg::len_t   aw_len_i,
  input  axi_mem_pkg::burst_t aw_burst_i,
  // Write data
  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  axi_mem_pkg::data_t  w_data_i,
  input  axi_mem_pkg::strb_t  w_strb_i,
  input  logic                w_last_i,
  // Write response
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output axi_mem_pkg::id_t    b_id_o,
  output axi_mem_pkg::resp_t  b_resp_o,
  // Read address
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  axi_mem_pkg::id_t    ar_id_i,
  input  axi_mem_pkg::addr_t  ar_addr_i,
  input  axi_mem_pkg::len_t   ar_len_i,
  input  axi_mem_pkg::burst_t ar_burst_i,
  // Read data
  output logic                r_valid_o,
  input  logic                r_ready_i,
  output axi_mem_pkg::id_t    r_id_o,
  output axi_mem_pkg::data_t  r_data_o,
  output axi_mem_pkg::resp_t  r_resp_o,
  output logic                r_last_o
);
  import axi_mem_pkg::*;

  addr_t beat_addr;
  logic  last_beat;
  logic  burst_err;
  logic  load_wr;
  logic  load_rd;
  logic  step;
  logic  mem_we;
  logic  mem_re;

  axi_mem_fsm u_fsm (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .aw_valid_i  (aw_valid_i),
    .aw_id_i     (aw_id_i),
    .aw_ready_o  (aw_ready_o),
    .w_valid_i   (w_valid_i),
    .w_last_i    (w_last_i),
    .w_ready_o   (w_ready_o),
    .b_ready_i   (b_ready_i),
    .b_valid_o   (b_valid_o),
    .b_id_o      (b_id_o),
    .b_resp_o    (b_resp_o),
    .ar_valid_i  (ar_valid_i),
    .ar_id_i     (ar_id_i),
    .ar_ready_o  (ar_ready_o),
    .r_ready_i   (r_ready_i),
    .r_valid_o   (r_valid_o),
    .r_id_o      (r_id_o),
    .r_resp_o    (r_resp_o),
    .r_last_o    (r_last_o),
    .last_beat_i (last_beat),
    .burst_err_i (burst_err),
    .load_wr_o   (load_wr),
    .load_rd_o   (load_rd),
    .step_o      (step),
    .mem_we_o    (mem_we),
    .mem_re_o    (mem_re)
  );

  axi_burst_counter u_cnt (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .aw_addr_i   (aw_addr_i),
    .aw_len_i    (aw_len_i),
    .aw_burst_i  (aw_burst_i),
    .ar_addr_i   (ar_addr_i),
    .ar_len_i    (ar_len_i),
    .ar_burst_i  (ar_burst_i),
    .load_wr_i   (load_wr),
    .load_rd_i   (load_rd),
    .step_i      (step),
    .addr_o      (beat_addr),
    .last_beat_o (last_beat),
    .burst_err_o (burst_err)
  );

  // W payload goes straight to the array
  axi_mem_array u_mem (
    .clk_i   (clk_i),
    .addr_i  (beat_addr),
    .we_i    (mem_we),
    .strb_i  (w_strb_i),
    .wdata_i (w_data_i),
    .re_i    (mem_re),
    .rdata_o (r_data_o)
  );

endmodule
